/* tests/rs_stim.txt */
# test dv opcode robid pdst src1 pend1 src2 pend2 we0 wreg0 we1 wreg1, all hex
# a line holding only a dash closes the test
1 1 0 01 10 01 0 02 0 0 00 0 00
1 1 3 02 11 03 0 04 0 0 00 0 00
1 1 7 03 12 05 0 06 0 0 00 0 00
-
2 1 1 04 13 07 1 08 0 0 00 0 00
2 0 0 00 00 00 0 00 0 1 07 0 00
2 1 2 05 14 09 0 0a 1 0 00 1 0a
2 1 4 06 15 0b 1 0c 1 0 00 0 00
2 0 0 00 00 00 0 00 0 0 00 1 0b
2 0 0 00 00 00 0 00 0 1 0c 0 00
-
3 1 5 07 16 20 1 01 0 0 00 0 00
3 1 6 08 17 02 0 03 0 0 00 0 00
3 1 7 09 18 20 1 20 1 0 00 0 00
3 0 0 00 00 00 0 00 0 0 00 0 00
3 0 0 00 00 00 0 00 0 0 00 0 00
3 1 0 0a 19 04 0 20 1 0 00 0 00
3 0 0 00 00 00 0 00 0 1 20 0 00
-
4 1 1 0b 1a 30 1 05 0 0 00 0 00
4 1 2 0c 1b 31 1 06 0 0 00 0 00
4 1 3 0d 1c 32 1 07 0 0 00 0 00
4 1 4 0e 1d 33 1 08 0 0 00 0 00
4 1 5 0f 1e 34 1 09 0 0 00 0 00
4 1 6 10 1f 35 1 0a 0 0 00 0 00
4 1 7 11 20 36 1 0b 0 0 00 0 00
4 1 0 12 21 37 1 0c 0 0 00 0 00
4 0 0 00 00 00 0 00 0 0 00 0 00
4 0 0 00 00 00 0 00 0 0 00 1 33
4 0 0 00 00 00 0 00 0 0 00 0 00
4 1 3 13 22 38 1 0d 0 0 00 0 00
4 0 0 00 00 00 0 00 0 1 30 1 31
4 0 0 00 00 00 0 00 0 1 32 1 34
4 0 0 00 00 00 0 00 0 1 35 1 36
4 0 0 00 00 00 0 00 0 1 37 1 38
-
5 1 1 14 23 3a 0 3b 0 0 00 0 00
5 1 2 15 24 3c 1 3d 1 1 3c 1 3d
5 1 3 16 25 3e 1 3f 0 0 00 0 00
5 1 4 17 26 00 0 00 0 0 00 1 3e
-

/* filelist.f */
rtl/rs_pkg.sv
rtl/rs_entry_if.sv
rtl/rs_reg_trk.sv
rtl/rs_entry.sv
rtl/rs_age_matrix.sv
rtl/rs.sv
tests/rs_checker.sv
tests/tb_rs.sv

/* tests/tb_rs.sv */
`timescale 1ns/100ps

module tb_rs;

    logic                clk;
    logic                reset;
    logic                disp_valid;
    rs_pkg::t_disp_pkt   disp_pkt;
    logic                prf_wr_en  [rs_pkg::PRF_NUM_WRITES];
    rs_pkg::t_prf_wr_pkt prf_wr_pkt [rs_pkg::PRF_NUM_WRITES];
    logic                rs_full;
    logic                iss_valid;
    rs_pkg::t_iss_pkt    iss_pkt;

    int                  test_num;
    logic                test_end;
    logic                report;
    logic                drained;
    int                  err_count;

    string               stim_lines[$];
    int                  n_data      = 0;
    int                  cycle_cnt   = 0;
    int                  cycle_limit = 1000;
    logic                stim_ok;
    logic                bad_line;

    always #50 clk = ~clk;

    rs UUT (
        .clk        (clk),
        .reset      (reset),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt),
        .prf_wr_en  (prf_wr_en),
        .prf_wr_pkt (prf_wr_pkt),
        .rs_full    (rs_full),
        .iss_valid  (iss_valid),
        .iss_pkt    (iss_pkt)
    );

    rs_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt),
        .prf_wr_en  (prf_wr_en),
        .prf_wr_pkt (prf_wr_pkt),
        .rs_full    (rs_full),
        .iss_valid  (iss_valid),
        .iss_pkt    (iss_pkt),
        .test_num   (test_num),
        .test_end   (test_end),
        .report     (report),
        .drained    (drained),
        .err_count  (err_count)
    );

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Comment and blank lines are dropped
    // A lone dash closes a test
    task automatic load_stim();
        int    fd;
        int    code;
        string line;
        fd      = $fopen("tests/rs_stim.txt", "r");
        stim_ok = (fd != 0);
        if (stim_ok) begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line[0] != "#" && line[0] != "\n") begin
                    stim_lines.push_back(line);
                    if (line[0] != "-") begin
                        n_data++;
                    end
                end
            end
            $fclose(fd);
            cycle_limit = n_data + 4 * rs_pkg::RS_NUM_ENTRIES + 20;
        end
    endtask

    task automatic drive_idle();
        disp_valid = 1'b0;
        disp_pkt   = '0;
        for (int w = 0; w < rs_pkg::PRF_NUM_WRITES; w++) begin
            prf_wr_en[w]  = 1'b0;
            prf_wr_pkt[w] = '0;
        end
    endtask

    task automatic drive_line(input string line);
        int tnum, dv, op, rob, pdst, s1, p1, s2, p2, we0, wr0, we1, wr1;
        int n;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tnum, dv, op, rob, pdst, s1, p1, s2, p2, we0, wr0, we1, wr1);
        if (n != 13) begin
            $display("Stimulus line could not be parsed: %s", line);
            bad_line = 1'b1;
        end
        test_num                         = tnum;
        disp_valid                       = dv[0];
        disp_pkt.opcode                  = rs_pkg::t_rs_opcode'(op[2:0]);
        disp_pkt.robid                   = rob[rs_pkg::ROBID_W-1:0];
        disp_pkt.pdst                    = pdst[rs_pkg::PREG_W-1:0];
        disp_pkt.src[rs_pkg::SRC1].preg  = s1[rs_pkg::PREG_W-1:0];
        disp_pkt.src[rs_pkg::SRC1].pend  = p1[0];
        disp_pkt.src[rs_pkg::SRC2].preg  = s2[rs_pkg::PREG_W-1:0];
        disp_pkt.src[rs_pkg::SRC2].pend  = p2[0];
        prf_wr_en[0]                     = we0[0];
        prf_wr_pkt[0].preg               = wr0[rs_pkg::PREG_W-1:0];
        prf_wr_en[1]                     = we1[0];
        prf_wr_pkt[1].preg               = wr1[rs_pkg::PREG_W-1:0];
    endtask

    // Let the station empty out before closing the test
    task automatic finish_test();
        drive_idle();
        while (!drained) begin
            @(posedge clk);
            #10;
        end
        test_end = 1'b1;
        @(posedge clk);
        #10;
        test_end = 1'b0;
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        test_num = 0;
        test_end = 1'b0;
        report   = 1'b0;
        bad_line = 1'b0;
        drive_idle();
        load_stim();
        if (!stim_ok) begin
            $display("Stimulus file tests/rs_stim.txt could not be opened");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            #10;
            reset = 1'b0;
            foreach (stim_lines[i]) begin
                @(posedge clk);
                #10;
                if (stim_lines[i][0] == "-") begin
                    finish_test();
                end else begin
                    drive_line(stim_lines[i]);
                end
            end
            @(posedge clk);
            #10;
            report = 1'b1;
            @(posedge clk);
            #10;
            report = 1'b0;
            if (err_count == 0 && !bad_line) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

/* tests/rs_checker.sv */
`timescale 1ns/100ps

module rs_checker (
    input  logic                clk,
    input  logic                reset,

    input  logic                disp_valid,
    input  rs_pkg::t_disp_pkt   disp_pkt,
    input  logic                prf_wr_en  [rs_pkg::PRF_NUM_WRITES],
    input  rs_pkg::t_prf_wr_pkt prf_wr_pkt [rs_pkg::PRF_NUM_WRITES],

    input  logic                rs_full,
    input  logic                iss_valid,
    input  rs_pkg::t_iss_pkt    iss_pkt,

    input  int                  test_num,
    input  logic                test_end,
    input  logic                report,
    output logic                drained,
    output int                  err_count
);

    // Reference model of the station contents
    logic                      m_valid [rs_pkg::RS_NUM_ENTRIES];
    logic                      m_pend  [rs_pkg::RS_NUM_ENTRIES][rs_pkg::NUM_SOURCES];
    logic [rs_pkg::PREG_W-1:0] m_preg  [rs_pkg::RS_NUM_ENTRIES][rs_pkg::NUM_SOURCES];
    int                        m_age   [rs_pkg::RS_NUM_ENTRIES];
    rs_pkg::t_iss_pkt          m_pkt   [rs_pkg::RS_NUM_ENTRIES];
    rs_pkg::t_iss_pkt          exp_pkt;
    logic                      exp_valid;
    logic                      exp_full;
    logic                      armed;
    int                        age_ctr;
    int                        accepted;
    int                        issued;
    int                        test_errs;
    int                        tests_pass;
    int                        tests_fail;

    initial begin
        armed      = 1'b0;
        exp_valid  = 1'b0;
        exp_full   = 1'b0;
        drained    = 1'b1;
        err_count  = 0;
        age_ctr    = 0;
        accepted   = 0;
        issued     = 0;
        test_errs  = 0;
        tests_pass = 0;
        tests_fail = 0;
    end

    function automatic logic wb_hit(input logic [rs_pkg::PREG_W-1:0] preg);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < rs_pkg::PRF_NUM_WRITES; w++) begin
            if (prf_wr_en[w] && (prf_wr_pkt[w].preg == preg)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic flag_err(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count++;
        test_errs++;
    endtask

    // Advance the model on each edge with the inputs sampled there
    always @(posedge clk) begin : model_step
        int g;
        int slot;
        int nvalid;
        g      = -1;
        slot   = -1;
        nvalid = 0;
        if (reset) begin
            for (int i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin
                m_valid[i] = 1'b0;
            end
            exp_valid = 1'b0;
            armed     = 1'b1;
        end else begin
            // Oldest entry with both sources ready wins
            for (int i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin
                if (m_valid[i]) begin
                    nvalid++;
                    if (!m_pend[i][0] && !m_pend[i][1] && (g < 0 || m_age[i] < m_age[g])) begin
                        g = i;
                    end
                end
            end
            exp_valid = (g >= 0);
            if (g >= 0) begin
                exp_pkt = m_pkt[g];
            end
            for (int i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin
                for (int s = 0; s < rs_pkg::NUM_SOURCES; s++) begin
                    if (m_valid[i] && wb_hit(m_preg[i][s])) begin
                        m_pend[i][s] = 1'b0;
                    end
                end
            end
            if (disp_valid && nvalid < rs_pkg::RS_NUM_ENTRIES) begin
                for (int i = rs_pkg::RS_NUM_ENTRIES - 1; i >= 0; i--) begin
                    if (!m_valid[i]) begin
                        slot = i;
                    end
                end
                age_ctr++;
                accepted++;
                m_valid[slot] = 1'b1;
                m_age[slot]   = age_ctr;
                for (int s = 0; s < rs_pkg::NUM_SOURCES; s++) begin
                    m_preg[slot][s] = disp_pkt.src[s].preg;
                    m_pend[slot][s] = disp_pkt.src[s].pend && !wb_hit(disp_pkt.src[s].preg);
                end
                m_pkt[slot].opcode = disp_pkt.opcode;
                m_pkt[slot].robid  = disp_pkt.robid;
                m_pkt[slot].pdst   = disp_pkt.pdst;
                m_pkt[slot].psrc1  = disp_pkt.src[0].preg;
                m_pkt[slot].psrc2  = disp_pkt.src[1].preg;
            end
            if (g >= 0) begin
                m_valid[g] = 1'b0;
            end
        end
        nvalid = 0;
        for (int i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin
            if (m_valid[i]) begin
                nvalid++;
            end
        end
        exp_full = (nvalid == rs_pkg::RS_NUM_ENTRIES);
        drained  = (nvalid == 0) && !exp_valid;
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (armed) begin
            if (iss_valid !== exp_valid) begin
                flag_err($sformatf("iss_valid expected %b got %b", exp_valid, iss_valid));
            end else if (exp_valid && (iss_pkt !== exp_pkt)) begin
                flag_err($sformatf("iss_pkt expected %h got %h", exp_pkt, iss_pkt));
            end
            if (iss_valid === 1'b1) begin
                issued++;
            end
            if (rs_full !== exp_full) begin
                flag_err($sformatf("rs_full expected %b got %b", exp_full, rs_full));
            end
        end
        if (test_end) begin
            if (test_errs == 0) begin
                tests_pass++;
                $display("test %0d: pass", test_num);
            end else begin
                tests_fail++;
                $display("test %0d: fail with %0d errors", test_num, test_errs);
            end
            test_errs = 0;
        end
        if (report) begin
            if (issued != accepted) begin
                flag_err($sformatf("issued %0d of %0d dispatched", issued, accepted));
            end
            $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail,
                     err_count);
        end
    end

endmodule

/* rtl/rs.sv */
`timescale 1ns/100ps

module rs (
    input  logic                clk,
    input  logic                reset,

    input  logic                disp_valid,
    input  rs_pkg::t_disp_pkt   disp_pkt,

    input  logic                prf_wr_en  [rs_pkg::PRF_NUM_WRITES],
    input  rs_pkg::t_prf_wr_pkt prf_wr_pkt [rs_pkg::PRF_NUM_WRITES],

    output logic                rs_full,
    output logic                iss_valid,
    output rs_pkg::t_iss_pkt    iss_pkt
);

    logic [rs_pkg::RS_NUM_ENTRIES-1:0] valid_vec;
    logic [rs_pkg::RS_NUM_ENTRIES-1:0] req_vec;
    logic [rs_pkg::RS_NUM_ENTRIES-1:0] gnt_vec;
    logic [rs_pkg::RS_NUM_ENTRIES-1:0] alloc_vec;
    logic [rs_pkg::RS_ENTRY_IDX_W-1:0] alloc_idx;
    logic [rs_pkg::RS_ENTRY_IDX_W-1:0] gnt_idx;
    logic                              do_alloc;
    rs_pkg::t_iss_pkt                  ent_iss [rs_pkg::RS_NUM_ENTRIES];

    rs_entry_if ent_if [rs_pkg::RS_NUM_ENTRIES] ();

    assign rs_full  = &valid_vec;
    // A strobe while full is dropped here
    assign do_alloc = disp_valid & ~rs_full;

    // Scan downward so the lowest free index is left in alloc_idx
    always_comb begin
        alloc_idx = '0;
        for (int i = rs_pkg::RS_NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_vec[i]) begin
                alloc_idx = rs_pkg::RS_ENTRY_IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin
            alloc_vec[i] = do_alloc & (alloc_idx == rs_pkg::RS_ENTRY_IDX_W'(i));
        end
    end

    generate
        for (genvar i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin : g_entry
            assign ent_if[i].alloc = alloc_vec[i];
            assign ent_if[i].disp  = disp_pkt;
            assign ent_if[i].gnt   = gnt_vec[i];

            assign valid_vec[i] = ent_if[i].valid;
            assign req_vec[i]   = ent_if[i].req;
            assign ent_iss[i]   = ent_if[i].iss;

            rs_entry u_entry (
                .clk        (clk),
                .reset      (reset),
                .prf_wr_en  (prf_wr_en),
                .prf_wr_pkt (prf_wr_pkt),
                .ent        (ent_if[i].entry)
            );
        end
    endgenerate

    rs_age_matrix u_age_matrix (
        .clk       (clk),
        .reset     (reset),
        .alloc_vec (alloc_vec),
        .req_vec   (req_vec),
        .gnt_vec   (gnt_vec)
    );

    // Encode the one-hot grant for the packet mux
    always_comb begin
        gnt_idx = '0;
        for (int i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin
            if (gnt_vec[i]) begin
                gnt_idx = rs_pkg::RS_ENTRY_IDX_W'(i);
            end
        end
    end

    // Issue stage register loaded at the end of the selection cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= |gnt_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (|gnt_vec) begin
            iss_pkt <= ent_iss[gnt_idx];
        end
    end

endmodule

/* rtl/rs_age_matrix.sv */
`timescale 1ns/100ps

module rs_age_matrix (
    input  logic                              clk,
    input  logic                              reset,

    input  logic [rs_pkg::RS_NUM_ENTRIES-1:0] alloc_vec,
    input  logic [rs_pkg::RS_NUM_ENTRIES-1:0] req_vec,
    output logic [rs_pkg::RS_NUM_ENTRIES-1:0] gnt_vec
);

    // older_q[i][j] is set while entry i is older than entry j
    logic [rs_pkg::RS_NUM_ENTRIES-1:0][rs_pkg::RS_NUM_ENTRIES-1:0] older_q;
    logic [rs_pkg::RS_NUM_ENTRIES-1:0][rs_pkg::RS_NUM_ENTRIES-1:0] older_nxt;
    logic [rs_pkg::RS_NUM_ENTRIES-1:0]                             blocked;

    // New entry becomes younger than everything else
    always_comb begin
        older_nxt = older_q;
        for (int i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin
            for (int j = 0; j < rs_pkg::RS_NUM_ENTRIES; j++) begin
                if (alloc_vec[j] && (i != j)) begin
                    older_nxt[i][j] = 1'b1;
                end
                if (alloc_vec[i]) begin
                    older_nxt[i][j] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            older_q <= '0;
        end else begin
            older_q <= older_nxt;
        end
    end

    // A requester loses if any other requester is older
    always_comb begin
        blocked = '0;
        for (int i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin
            for (int j = 0; j < rs_pkg::RS_NUM_ENTRIES; j++) begin
                if (req_vec[j] && older_q[j][i]) begin
                    blocked[i] = 1'b1;
                end
            end
        end
    end

    // Valid entries are totally ordered, so at most one bit survives
    assign gnt_vec = req_vec & ~blocked;

endmodule

/* rtl/rs_entry.sv */
`timescale 1ns/100ps

module rs_entry (
    input  logic                clk,
    input  logic                reset,

    input  logic                prf_wr_en  [rs_pkg::PRF_NUM_WRITES],
    input  rs_pkg::t_prf_wr_pkt prf_wr_pkt [rs_pkg::PRF_NUM_WRITES],

    rs_entry_if.entry           ent
);

    rs_pkg::t_rs_ent_state              state_q;
    rs_pkg::t_rs_ent_state              state_nxt;
    rs_pkg::t_disp_pkt                  disp_q;
    logic [rs_pkg::NUM_SOURCES-1:0]     src_ready;

    // Occupancy FSM that frees the entry once the age matrix picks it
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            rs_pkg::IDLE: begin
                if (ent.alloc) begin
                    state_nxt = rs_pkg::VALID;
                end
            end
            rs_pkg::VALID: begin
                if (ent.gnt) begin
                    state_nxt = rs_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = rs_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= rs_pkg::IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    assign ent.valid = (state_q == rs_pkg::VALID);

    // Micro-op payload
    always_ff @(posedge clk) begin
        if (ent.alloc) begin
            disp_q <= ent.disp;
        end
    end

    // One wakeup tracker per source
    generate
        for (genvar srcx = 0; srcx < rs_pkg::NUM_SOURCES; srcx++) begin : g_src_trk
            rs_reg_trk u_reg_trk (
                .clk        (clk),
                .reset      (reset),
                .alloc      (ent.alloc),
                .alloc_src  (ent.disp.src[srcx]),
                .prf_wr_en  (prf_wr_en),
                .prf_wr_pkt (prf_wr_pkt),
                .ready      (src_ready[srcx])
            );
        end
    endgenerate

    assign ent.req = ent.valid & (&src_ready);

    always_comb begin
        ent.iss.opcode = disp_q.opcode;
        ent.iss.robid  = disp_q.robid;
        ent.iss.pdst   = disp_q.pdst;
        ent.iss.psrc1  = disp_q.src[rs_pkg::SRC1].preg;
        ent.iss.psrc2  = disp_q.src[rs_pkg::SRC2].preg;
    end

endmodule

/* rtl/rs_reg_trk.sv */
`timescale 1ns/100ps

module rs_reg_trk (
    input  logic                clk,
    input  logic                reset,

    input  logic                alloc,
    input  rs_pkg::t_src_trk    alloc_src,

    input  logic                prf_wr_en  [rs_pkg::PRF_NUM_WRITES],
    input  rs_pkg::t_prf_wr_pkt prf_wr_pkt [rs_pkg::PRF_NUM_WRITES],

    output logic                ready
);

    logic [rs_pkg::PREG_W-1:0] preg_q;
    logic                      pend_q;
    logic                      alloc_hit;
    logic                      trk_hit;

    // Compare every write-back port against the incoming and the held source
    always_comb begin
        alloc_hit = 1'b0;
        trk_hit   = 1'b0;
        for (int w = 0; w < rs_pkg::PRF_NUM_WRITES; w++) begin
            if (prf_wr_en[w] && (prf_wr_pkt[w].preg == alloc_src.preg)) begin
                alloc_hit = 1'b1;
            end
            if (prf_wr_en[w] && (prf_wr_pkt[w].preg == preg_q)) begin
                trk_hit = 1'b1;
            end
        end
    end

    // A write-back in the dispatch cycle already satisfies the source
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= 1'b0;
        end else if (alloc) begin
            pend_q <= alloc_src.pend & ~alloc_hit;
        end else if (trk_hit) begin
            pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            preg_q <= alloc_src.preg;
        end
    end

    assign ready = ~pend_q;

endmodule

/* rtl/rs_entry_if.sv */
`timescale 1ns/100ps

interface rs_entry_if;

    // Allocation from the free-entry picker
    logic              alloc;
    rs_pkg::t_disp_pkt disp;

    // Entry status back to the control
    logic              valid;
    logic              req;

    // Grant from the age matrix
    logic              gnt;

    // Stored micro-op in issue form
    rs_pkg::t_iss_pkt  iss;

    modport entry (
        input  alloc,
        input  disp,
        input  gnt,
        output valid,
        output req,
        output iss
    );

    modport ctrl (
        output alloc,
        output disp,
        output gnt,
        input  valid,
        input  req,
        input  iss
    );

endinterface

/* rtl/rs_pkg.sv */
package rs_pkg;

    // Station geometry
    localparam int RS_NUM_ENTRIES = 8;
    localparam int RS_ENTRY_IDX_W = 3;

    // Rename and retire widths
    localparam int PREG_W  = 6;
    localparam int ROBID_W = 5;

    // Sources per micro-op and their slots
    localparam int NUM_SOURCES = 2;
    localparam int SRC1        = 0;
    localparam int SRC2        = 1;

    // Physical register file write-back ports
    localparam int PRF_NUM_WRITES = 2;

    // Integer ALU operations
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        LUI
    } t_rs_opcode;

    // Entry occupancy
    typedef enum logic {
        IDLE,
        VALID
    } t_rs_ent_state;

    // One renamed source as it arrives from dispatch
    typedef struct packed {
        logic [PREG_W-1:0] preg;
        logic              pend;
    } t_src_trk;

    // Renamed micro-op written into a free entry
    typedef struct packed {
        t_rs_opcode                      opcode;
        logic [ROBID_W-1:0]              robid;
        logic [PREG_W-1:0]               pdst;
        t_src_trk [NUM_SOURCES-1:0]      src;
    } t_disp_pkt;

    // Write-back broadcast with its enable carried alongside
    typedef struct packed {
        logic [PREG_W-1:0] preg;
    } t_prf_wr_pkt;

    // Packet sent to execution without operand data
    typedef struct packed {
        t_rs_opcode         opcode;
        logic [ROBID_W-1:0] robid;
        logic [PREG_W-1:0]  pdst;
        logic [PREG_W-1:0]  psrc1;
        logic [PREG_W-1:0]  psrc2;
    } t_iss_pkt;

endpackage
